// ==== lsu_agen.sv ====
/*
  Address stage of the load pipe, covering EX0 to EX2.
  Registers the issue into EX1, adds base and offset, sends the line read
  to the L1 data cache and hands the load on to the EX2 consumers.
*/

`timescale 1ns/1ps

module lsu_agen (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_kill,

  input  logic                    i_issue_valid,
  input  lsu_cfg_pkg::data_t      i_issue_base,
  input  lsu_cfg_pkg::offset_t    i_issue_offset,
  input  lsu_op_pkg::size_e       i_issue_size,
  input  lsu_op_pkg::sign_e       i_issue_sign,
  input  lsu_cfg_pkg::rd_tag_t    i_issue_rd,

  output logic                    o_l1d_rd_valid,
  output lsu_cfg_pkg::paddr_t     o_l1d_rd_paddr,

  output logic                    o_ex2_valid,
  output lsu_cfg_pkg::paddr_t     o_ex2_paddr,
  output lsu_op_pkg::size_e       o_ex2_size,
  output lsu_op_pkg::sign_e       o_ex2_sign,
  output lsu_cfg_pkg::rd_tag_t    o_ex2_rd
);

  // EX1 stage
  logic                  r_ex1_valid;
  lsu_cfg_pkg::data_t    r_ex1_base;
  lsu_cfg_pkg::offset_t  r_ex1_offset;
  lsu_op_pkg::size_e     r_ex1_size;
  lsu_op_pkg::sign_e     r_ex1_sign;
  lsu_cfg_pkg::rd_tag_t  r_ex1_rd;

  lsu_cfg_pkg::data_t    w_ex1_sum;
  lsu_cfg_pkg::paddr_t   w_ex1_paddr;

  // --------------------------------------------------
  // EX0 to EX1
  // --------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_valid <= 1'b0;
    end else begin
      r_ex1_valid <= i_issue_valid & ~i_kill;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_issue_valid) begin
      r_ex1_base   <= i_issue_base;
      r_ex1_offset <= i_issue_offset;
      r_ex1_size   <= i_issue_size;
      r_ex1_sign   <= i_issue_sign;
      r_ex1_rd     <= i_issue_rd;
    end
  end

  // --------------------------------------------------
  // EX1 address and cache read
  // --------------------------------------------------
  assign w_ex1_sum = r_ex1_base +
                     {{(lsu_cfg_pkg::ALEN_W - $bits(lsu_cfg_pkg::offset_t)){r_ex1_offset[11]}},
                      r_ex1_offset};
  // Without translation the truncated sum is the physical address
  assign w_ex1_paddr = w_ex1_sum[lsu_cfg_pkg::PADDR_W-1:0];

  assign o_l1d_rd_valid = r_ex1_valid;
  assign o_l1d_rd_paddr = {w_ex1_paddr[lsu_cfg_pkg::PADDR_W-1:lsu_cfg_pkg::DCACHE_OFF_W],
                           {lsu_cfg_pkg::DCACHE_OFF_W{1'b0}}};

  // --------------------------------------------------
  // EX1 to EX2
  // --------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ex2_valid <= 1'b0;
    end else begin
      o_ex2_valid <= r_ex1_valid & ~i_kill;
    end
  end

  always_ff @(posedge i_clk) begin
    if (r_ex1_valid) begin
      o_ex2_paddr <= w_ex1_paddr;
      o_ex2_size  <= r_ex1_size;
      o_ex2_sign  <= r_ex1_sign;
      o_ex2_rd    <= r_ex1_rd;
    end
  end

  // Issue side promises natural alignment; the merge relies on it
  a_ex1_aligned : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    r_ex1_valid |->
      ((((4'd1 << r_ex1_size) - 4'd1) & {1'b0, w_ex1_paddr[lsu_cfg_pkg::LANE_OFF_W-1:0]}) == 4'd0)
  ) else $error("EX1 load address %h not aligned for size %s", w_ex1_paddr, r_ex1_size.name());

endmodule

// ==== lsu_cfg_pkg.sv ====
/*
  Width and count definitions for the four-stage load pipe.
  Modules refer to these by scoped name, for example lsu_cfg_pkg::paddr_t.
  Physical address equals virtual address, so one address type covers both.
*/

package lsu_cfg_pkg;

  // --------------------------------------------------
  // Widths and counts
  // --------------------------------------------------
  localparam int ALEN_W          = 64;
  localparam int PADDR_W         = 40;
  localparam int DCACHE_DATA_B_W = 16;
  localparam int ALEN_B          = 8;
  localparam int RD_TAG_W        = 6;

  // Source 0 is the store queue, 1 the store buffer and 2 the miss unit
  localparam int FWD_SRC_NUM = 3;

  // Byte offset inside a cache read and inside a doubleword
  localparam int DCACHE_OFF_W = $clog2(DCACHE_DATA_B_W);
  localparam int LANE_OFF_W   = $clog2(ALEN_B);

  // --------------------------------------------------
  // Vector types
  // --------------------------------------------------
  typedef logic        [PADDR_W-1:0]           paddr_t;
  typedef logic signed [11:0]                  offset_t;
  typedef logic        [ALEN_W-1:0]            data_t;
  typedef logic        [ALEN_B-1:0]            byte_mask_t;
  typedef logic        [DCACHE_DATA_B_W*8-1:0] line_t;
  typedef logic        [RD_TAG_W-1:0]          rd_tag_t;

endpackage

// ==== lsu_fwd_align.sv ====
/*
  Lane alignment for one store-forwarding source in EX2.
  Keeps the lanes the load needs and shifts them down so that
  output lane 0 carries the load's first byte.
*/

`timescale 1ns/1ps

module lsu_fwd_align (
  input  lsu_cfg_pkg::paddr_t      i_ex2_paddr,
  input  lsu_op_pkg::size_e        i_ex2_size,
  input  lsu_cfg_pkg::byte_mask_t  i_src_dw,
  input  lsu_cfg_pkg::data_t       i_src_data,

  output lsu_cfg_pkg::byte_mask_t  o_lane_valid,
  output lsu_cfg_pkg::data_t       o_lane_data
);

  logic [lsu_cfg_pkg::LANE_OFF_W-1:0] w_lane_off;
  lsu_cfg_pkg::byte_mask_t            w_expected;
  lsu_cfg_pkg::byte_mask_t            w_hit_lanes;

  assign w_lane_off = i_ex2_paddr[lsu_cfg_pkg::LANE_OFF_W-1:0];

  // Lanes of the aligned doubleword the load reads
  assign w_expected  = lsu_op_pkg::size_mask(i_ex2_size, w_lane_off);
  assign w_hit_lanes = i_src_dw & w_expected;

  // Move the load's first lane down to lane 0
  assign o_lane_valid = w_hit_lanes >> w_lane_off;
  assign o_lane_data  = i_src_data >> {w_lane_off, 3'b000};

endmodule

// ==== lsu_load_merge.sv ====
/*
  EX2 merge and EX3 result stage of the load pipe.
  Sends the forwarding check, overlays forwarded bytes on the cache data,
  decides between writeback and replay, and registers the result into EX3.
  Lower source index has priority where sources overlap.
*/

`timescale 1ns/1ps

module lsu_load_merge (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_kill,

  input  logic                     i_ex2_valid,
  input  lsu_cfg_pkg::paddr_t      i_ex2_paddr,
  input  lsu_op_pkg::size_e        i_ex2_size,
  input  lsu_op_pkg::sign_e        i_ex2_sign,
  input  lsu_cfg_pkg::rd_tag_t     i_ex2_rd,

  input  logic                     i_l1d_hit,
  input  lsu_cfg_pkg::line_t       i_l1d_data,

  input  lsu_cfg_pkg::byte_mask_t  i_lane_valid [lsu_cfg_pkg::FWD_SRC_NUM],
  input  lsu_cfg_pkg::data_t       i_lane_data  [lsu_cfg_pkg::FWD_SRC_NUM],

  output logic                     o_fwd_chk_valid,
  output lsu_cfg_pkg::paddr_t      o_fwd_chk_paddr,
  output lsu_cfg_pkg::byte_mask_t  o_fwd_chk_dw,

  output logic                     o_wb_valid,
  output lsu_cfg_pkg::rd_tag_t     o_wb_rd,
  output lsu_cfg_pkg::data_t       o_wb_data,

  output logic                     o_replay_valid,
  output lsu_cfg_pkg::rd_tag_t     o_replay_rd,
  output lsu_cfg_pkg::paddr_t      o_replay_paddr
);

  logic [lsu_cfg_pkg::LANE_OFF_W-1:0] w_lane_off;
  lsu_cfg_pkg::byte_mask_t            w_need_mask;
  lsu_cfg_pkg::byte_mask_t            w_fwd_cover;
  lsu_cfg_pkg::data_t                 w_l1d_dw;
  lsu_cfg_pkg::data_t                 w_merged;
  lsu_cfg_pkg::data_t                 w_ext_data;
  logic                               w_full_cover;
  logic                               w_replay;
  logic                               w_signed;

  // EX3 stage
  logic                  r_ex3_wb_valid;
  logic                  r_ex3_replay_valid;
  lsu_cfg_pkg::rd_tag_t  r_ex3_rd;
  lsu_cfg_pkg::data_t    r_ex3_data;
  lsu_cfg_pkg::paddr_t   r_ex3_paddr;

  // --------------------------------------------------
  // Forwarding request
  // --------------------------------------------------
  assign w_lane_off      = i_ex2_paddr[lsu_cfg_pkg::LANE_OFF_W-1:0];
  assign o_fwd_chk_valid = i_ex2_valid;
  assign o_fwd_chk_paddr = {i_ex2_paddr[lsu_cfg_pkg::PADDR_W-1:lsu_cfg_pkg::LANE_OFF_W],
                            {lsu_cfg_pkg::LANE_OFF_W{1'b0}}};
  assign o_fwd_chk_dw    = lsu_op_pkg::size_mask(i_ex2_size, w_lane_off);

  // Needed lanes after alignment, starting at lane 0
  assign w_need_mask = lsu_op_pkg::size_mask(i_ex2_size, '0);

  // Cache bytes from the load's first byte upward
  assign w_l1d_dw = lsu_cfg_pkg::data_t'(
                      i_l1d_data >> {i_ex2_paddr[lsu_cfg_pkg::DCACHE_OFF_W-1:0], 3'b000});

  // --------------------------------------------------
  // Byte merge
  // --------------------------------------------------
  // Lower sources are applied last and overwrite higher ones
  always_comb begin
    w_merged    = w_l1d_dw;
    w_fwd_cover = '0;
    for (int src = lsu_cfg_pkg::FWD_SRC_NUM - 1; src >= 0; src--) begin
      for (int lane = 0; lane < lsu_cfg_pkg::ALEN_B; lane++) begin
        if (i_lane_valid[src][lane]) begin
          w_merged[lane*8 +: 8] = i_lane_data[src][lane*8 +: 8];
        end
      end
      w_fwd_cover = w_fwd_cover | i_lane_valid[src];
    end
  end

  assign w_full_cover = &(w_fwd_cover | ~w_need_mask);
  // A miss only matters when forwarding leaves a gap
  assign w_replay     = ~w_full_cover & ~i_l1d_hit;

  // Size and sign extension
  assign w_signed = (i_ex2_sign == lsu_op_pkg::SIGN_S);

  always_comb begin
    case (i_ex2_size)
      lsu_op_pkg::SIZE_B:
        w_ext_data = {{(lsu_cfg_pkg::ALEN_W-8){w_signed & w_merged[7]}}, w_merged[7:0]};
      lsu_op_pkg::SIZE_H:
        w_ext_data = {{(lsu_cfg_pkg::ALEN_W-16){w_signed & w_merged[15]}}, w_merged[15:0]};
      lsu_op_pkg::SIZE_W:
        w_ext_data = {{(lsu_cfg_pkg::ALEN_W-32){w_signed & w_merged[31]}}, w_merged[31:0]};
      default:
        w_ext_data = w_merged;
    endcase
  end

  // --------------------------------------------------
  // EX2 to EX3
  // --------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex3_wb_valid     <= 1'b0;
      r_ex3_replay_valid <= 1'b0;
    end else begin
      r_ex3_wb_valid     <= i_ex2_valid & ~i_kill & ~w_replay;
      r_ex3_replay_valid <= i_ex2_valid & ~i_kill & w_replay;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ex2_valid) begin
      r_ex3_rd    <= i_ex2_rd;
      r_ex3_data  <= w_ext_data;
      r_ex3_paddr <= i_ex2_paddr;
    end
  end

  assign o_wb_valid     = r_ex3_wb_valid;
  assign o_wb_rd        = r_ex3_rd;
  assign o_wb_data      = r_ex3_data;
  assign o_replay_valid = r_ex3_replay_valid;
  assign o_replay_rd    = r_ex3_rd;
  assign o_replay_paddr = r_ex3_paddr;

  // Alignment slices pass only lanes the load needs
  a_fwd_in_need : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_ex2_valid |-> ((w_fwd_cover & ~w_need_mask) == '0)
  ) else $error("Forwarded lanes %b outside needed lanes %b", w_fwd_cover, w_need_mask);

endmodule

// ==== lsu_op_pkg.sv ====
/*
  Load operation encodings shared by the pipe stages.
  Size is coded as log2 of the access bytes, so alignment checks can shift by it.
  size_mask gives the byte lanes a load needs inside its doubleword.
*/

package lsu_op_pkg;

  typedef enum logic [1:0] {
    SIZE_B  = 2'd0,
    SIZE_H  = 2'd1,
    SIZE_W  = 2'd2,
    SIZE_DW = 2'd3
  } size_e;

  typedef enum logic {
    SIGN_U = 1'b0,
    SIGN_S = 1'b1
  } sign_e;

  // --------------------------------------------------
  // Lanes needed by a load of the given size
  // --------------------------------------------------
  // Consecutive lanes starting at lane_off; an aligned load never wraps
  function automatic lsu_cfg_pkg::byte_mask_t size_mask(
    input size_e                                 size,
    input logic [lsu_cfg_pkg::LANE_OFF_W-1:0]    lane_off
  );
    lsu_cfg_pkg::byte_mask_t base;
    case (size)
      SIZE_B:  base = 8'h01;
      SIZE_H:  base = 8'h03;
      SIZE_W:  base = 8'h0f;
      default: base = 8'hff;
    endcase
    return base << lane_off;
  endfunction

endpackage

// ==== lsu_pipe_top.sv ====
/*
  Top level of the four-stage load pipe.
  Connects the address stage, one alignment slice per forwarding source
  and the merge stage. Results appear three cycles after issue.
*/

`timescale 1ns/1ps

module lsu_pipe_top (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_kill,

  input  logic                     i_issue_valid,
  input  lsu_cfg_pkg::data_t       i_issue_base,
  input  lsu_cfg_pkg::offset_t     i_issue_offset,
  input  lsu_op_pkg::size_e        i_issue_size,
  input  lsu_op_pkg::sign_e        i_issue_sign,
  input  lsu_cfg_pkg::rd_tag_t     i_issue_rd,

  output logic                     o_l1d_rd_valid,
  output lsu_cfg_pkg::paddr_t      o_l1d_rd_paddr,
  input  logic                     i_l1d_hit,
  input  lsu_cfg_pkg::line_t       i_l1d_data,

  output logic                     o_fwd_chk_valid,
  output lsu_cfg_pkg::paddr_t      o_fwd_chk_paddr,
  output lsu_cfg_pkg::byte_mask_t  o_fwd_chk_dw,
  input  lsu_cfg_pkg::byte_mask_t  i_fwd_dw   [lsu_cfg_pkg::FWD_SRC_NUM],
  input  lsu_cfg_pkg::data_t       i_fwd_data [lsu_cfg_pkg::FWD_SRC_NUM],

  output logic                     o_wb_valid,
  output lsu_cfg_pkg::rd_tag_t     o_wb_rd,
  output lsu_cfg_pkg::data_t       o_wb_data,

  output logic                     o_replay_valid,
  output lsu_cfg_pkg::rd_tag_t     o_replay_rd,
  output lsu_cfg_pkg::paddr_t      o_replay_paddr
);

  logic                     ex2_valid;
  lsu_cfg_pkg::paddr_t      ex2_paddr;
  lsu_op_pkg::size_e        ex2_size;
  lsu_op_pkg::sign_e        ex2_sign;
  lsu_cfg_pkg::rd_tag_t     ex2_rd;

  lsu_cfg_pkg::byte_mask_t  lane_valid [lsu_cfg_pkg::FWD_SRC_NUM];
  lsu_cfg_pkg::data_t       lane_data  [lsu_cfg_pkg::FWD_SRC_NUM];

  lsu_agen u_agen (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_kill         (i_kill),
    .i_issue_valid  (i_issue_valid),
    .i_issue_base   (i_issue_base),
    .i_issue_offset (i_issue_offset),
    .i_issue_size   (i_issue_size),
    .i_issue_sign   (i_issue_sign),
    .i_issue_rd     (i_issue_rd),
    .o_l1d_rd_valid (o_l1d_rd_valid),
    .o_l1d_rd_paddr (o_l1d_rd_paddr),
    .o_ex2_valid    (ex2_valid),
    .o_ex2_paddr    (ex2_paddr),
    .o_ex2_size     (ex2_size),
    .o_ex2_sign     (ex2_sign),
    .o_ex2_rd       (ex2_rd)
  );

  // One slice per source: store queue, store buffer, miss unit
  for (genvar src = 0; src < lsu_cfg_pkg::FWD_SRC_NUM; src++) begin : g_fwd
    lsu_fwd_align u_fwd_align (
      .i_ex2_paddr  (ex2_paddr),
      .i_ex2_size   (ex2_size),
      .i_src_dw     (i_fwd_dw[src]),
      .i_src_data   (i_fwd_data[src]),
      .o_lane_valid (lane_valid[src]),
      .o_lane_data  (lane_data[src])
    );
  end

  lsu_load_merge u_load_merge (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_kill          (i_kill),
    .i_ex2_valid     (ex2_valid),
    .i_ex2_paddr     (ex2_paddr),
    .i_ex2_size      (ex2_size),
    .i_ex2_sign      (ex2_sign),
    .i_ex2_rd        (ex2_rd),
    .i_l1d_hit       (i_l1d_hit),
    .i_l1d_data      (i_l1d_data),
    .i_lane_valid    (lane_valid),
    .i_lane_data     (lane_data),
    .o_fwd_chk_valid (o_fwd_chk_valid),
    .o_fwd_chk_paddr (o_fwd_chk_paddr),
    .o_fwd_chk_dw    (o_fwd_chk_dw),
    .o_wb_valid      (o_wb_valid),
    .o_wb_rd         (o_wb_rd),
    .o_wb_data       (o_wb_data),
    .o_replay_valid  (o_replay_valid),
    .o_replay_rd     (o_replay_rd),
    .o_replay_paddr  (o_replay_paddr)
  );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the load pipe testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_lsu_pipe \
  -f src.f \
  -o sim_lsu_pipe

./obj_dir/sim_lsu_pipe | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
  echo "Simulation reported failure, see sim.log"
  exit 1
fi

echo "Simulation finished without failure"

// ==== src.f ====
lsu_cfg_pkg.sv
lsu_op_pkg.sv
lsu_agen.sv
lsu_fwd_align.sv
lsu_load_merge.sv
lsu_pipe_top.sv
tb_lsu_mem_model.sv
tb_lsu_pipe.sv

// ==== tb_lsu_mem_model.sv ====
/*
  Testbench responders for the L1 data cache and the three forwarding sources.
  The cache answers one cycle after a read request; forwarding lanes are
  redrawn every cycle while i_fwd_on is high and are visible to the testbench.
*/

`timescale 1ns/1ps

module tb_lsu_mem_model (
  input  logic                     i_clk,
  input  logic                     i_fwd_on,
  input  logic                     i_rd_valid,
  input  lsu_cfg_pkg::paddr_t      i_rd_paddr,

  output logic                     o_hit,
  output lsu_cfg_pkg::line_t       o_data,
  output lsu_cfg_pkg::byte_mask_t  o_fwd_dw   [lsu_cfg_pkg::FWD_SRC_NUM],
  output lsu_cfg_pkg::data_t       o_fwd_data [lsu_cfg_pkg::FWD_SRC_NUM]
);

  logic                 req_valid;
  lsu_cfg_pkg::paddr_t  req_paddr;

  // Memory contents are a fixed function of the byte address
  function automatic logic [7:0] line_byte(input lsu_cfg_pkg::paddr_t addr);
    return addr[7:0] * 8'h9d + 8'h3b;
  endfunction

  initial begin
    o_hit     = 1'b0;
    o_data    = '0;
    req_valid = 1'b0;
    req_paddr = '0;
    for (int s = 0; s < lsu_cfg_pkg::FWD_SRC_NUM; s++) begin
      o_fwd_dw[s]   = '0;
      o_fwd_data[s] = '0;
    end
    forever begin
      // Request is stable in the middle of the EX1 cycle
      @(negedge i_clk);
      req_valid = i_rd_valid;
      req_paddr = i_rd_paddr;
      @(posedge i_clk);
      #1;
      // Cache hits when address bit 6 is clear
      // Miss data is random junk
      o_hit = req_valid & ~req_paddr[6];
      for (int i = 0; i < lsu_cfg_pkg::DCACHE_DATA_B_W; i++) begin
        o_data[i*8 +: 8] = o_hit ? line_byte(req_paddr + i) : 8'($urandom);
      end
      for (int s = 0; s < lsu_cfg_pkg::FWD_SRC_NUM; s++) begin
        o_fwd_dw[s]   = i_fwd_on ? 8'($urandom) : 8'h00;
        o_fwd_data[s] = {$urandom, $urandom};
      end
    end
  end

endmodule

// ==== tb_lsu_pipe.sv ====
/*
  Testbench for the four-stage load pipe.
  Issues random aligned loads, tracks them in a queue of pipe slots and
  checks the DUT outputs with concurrent assertions against the slot
  contents. Prints an error count and a pass or fail line at the end.
*/

`timescale 1ns/1ps

module tb_lsu_pipe;

  localparam int MAX_CYCLES = 2000;
  localparam int SEED       = 32'h66d8_e478;
  localparam int HIT        = 0;
  localparam int MISS       = 1;
  localparam int ANY        = 2;

  typedef struct packed {
    logic                  valid;
    lsu_cfg_pkg::paddr_t   addr;
    lsu_op_pkg::size_e     size;
    lsu_op_pkg::sign_e     sign;
    lsu_cfg_pkg::rd_tag_t  rd;
    logic                  replay;
    lsu_cfg_pkg::data_t    data;
  } slot_t;

  logic                     clk;
  logic                     reset_n;
  logic                     kill;
  logic                     issue_valid;
  lsu_cfg_pkg::data_t       issue_base;
  lsu_cfg_pkg::offset_t     issue_offset;
  lsu_op_pkg::size_e        issue_size;
  lsu_op_pkg::sign_e        issue_sign;
  lsu_cfg_pkg::rd_tag_t     issue_rd;
  logic                     l1d_rd_valid;
  lsu_cfg_pkg::paddr_t      l1d_rd_paddr;
  logic                     l1d_hit;
  lsu_cfg_pkg::line_t       l1d_data;
  logic                     fwd_chk_valid;
  lsu_cfg_pkg::paddr_t      fwd_chk_paddr;
  lsu_cfg_pkg::byte_mask_t  fwd_chk_dw;
  lsu_cfg_pkg::byte_mask_t  fwd_dw   [lsu_cfg_pkg::FWD_SRC_NUM];
  lsu_cfg_pkg::data_t       fwd_data [lsu_cfg_pkg::FWD_SRC_NUM];
  logic                     wb_valid;
  lsu_cfg_pkg::rd_tag_t     wb_rd;
  lsu_cfg_pkg::data_t       wb_data;
  logic                     replay_valid;
  lsu_cfg_pkg::rd_tag_t     replay_rd;
  lsu_cfg_pkg::paddr_t      replay_paddr;
  logic                     fwd_on;

  // Slot 0 is EX3, slot 3 is EX0
  slot_t                    pipe_q [$];

  logic                     exp_rd_valid;
  logic                     exp_chk_valid;
  logic                     exp_wb_valid;
  logic                     exp_replay_valid;
  lsu_cfg_pkg::paddr_t      exp_line;
  lsu_cfg_pkg::paddr_t      exp_chk_paddr;
  lsu_cfg_pkg::byte_mask_t  exp_chk_dw;
  lsu_cfg_pkg::rd_tag_t     exp_rd;
  lsu_cfg_pkg::data_t       exp_data;
  lsu_cfg_pkg::paddr_t      exp_paddr;
  int                       err_count = 0;
  int                       cycle_cnt = 0;

  initial clk = 1'b0;
  always #4 clk = ~clk;

  lsu_pipe_top dut_i (
    .i_clk (clk), .i_reset_n (reset_n), .i_kill (kill),
    .i_issue_valid (issue_valid), .i_issue_base (issue_base),
    .i_issue_offset (issue_offset), .i_issue_size (issue_size),
    .i_issue_sign (issue_sign), .i_issue_rd (issue_rd),
    .o_l1d_rd_valid (l1d_rd_valid), .o_l1d_rd_paddr (l1d_rd_paddr),
    .i_l1d_hit (l1d_hit), .i_l1d_data (l1d_data),
    .o_fwd_chk_valid (fwd_chk_valid), .o_fwd_chk_paddr (fwd_chk_paddr),
    .o_fwd_chk_dw (fwd_chk_dw), .i_fwd_dw (fwd_dw), .i_fwd_data (fwd_data),
    .o_wb_valid (wb_valid), .o_wb_rd (wb_rd), .o_wb_data (wb_data),
    .o_replay_valid (replay_valid), .o_replay_rd (replay_rd),
    .o_replay_paddr (replay_paddr)
  );

  tb_lsu_mem_model u_mem_model (
    .i_clk (clk), .i_fwd_on (fwd_on),
    .i_rd_valid (l1d_rd_valid), .i_rd_paddr (l1d_rd_paddr),
    .o_hit (l1d_hit), .o_data (l1d_data),
    .o_fwd_dw (fwd_dw), .o_fwd_data (fwd_data)
  );

  task automatic note_fail(input string msg);
    err_count++;
    $display("Fail at %0t: %s", $time, msg);
  endtask

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  a_rd_valid : assert property (@(posedge clk) disable iff (!reset_n)
    l1d_rd_valid == exp_rd_valid)
    else note_fail($sformatf("cache read valid %b", $sampled(l1d_rd_valid)));
  a_rd_paddr : assert property (@(posedge clk) disable iff (!reset_n)
    exp_rd_valid |-> l1d_rd_paddr == exp_line)
    else note_fail($sformatf("cache read address %h, expected %h",
                             $sampled(l1d_rd_paddr), $sampled(exp_line)));
  a_chk_valid : assert property (@(posedge clk) disable iff (!reset_n)
    fwd_chk_valid == exp_chk_valid)
    else note_fail($sformatf("forward check valid %b", $sampled(fwd_chk_valid)));
  a_chk_req : assert property (@(posedge clk) disable iff (!reset_n)
    exp_chk_valid |-> fwd_chk_paddr == exp_chk_paddr && fwd_chk_dw == exp_chk_dw)
    else note_fail($sformatf("forward check %h/%h, expected %h/%h",
                             $sampled(fwd_chk_paddr), $sampled(fwd_chk_dw),
                             $sampled(exp_chk_paddr), $sampled(exp_chk_dw)));
  a_wb_valid : assert property (@(posedge clk) disable iff (!reset_n)
    wb_valid == exp_wb_valid)
    else note_fail($sformatf("writeback valid %b", $sampled(wb_valid)));
  a_replay_valid : assert property (@(posedge clk) disable iff (!reset_n)
    replay_valid == exp_replay_valid)
    else note_fail($sformatf("replay valid %b", $sampled(replay_valid)));
  a_wb_result : assert property (@(posedge clk) disable iff (!reset_n)
    exp_wb_valid |-> wb_rd == exp_rd && wb_data == exp_data)
    else note_fail($sformatf("writeback tag %0d data %h, expected tag %0d data %h",
                             $sampled(wb_rd), $sampled(wb_data),
                             $sampled(exp_rd), $sampled(exp_data)));
  a_replay_result : assert property (@(posedge clk) disable iff (!reset_n)
    exp_replay_valid |-> replay_rd == exp_rd && replay_paddr == exp_paddr)
    else note_fail($sformatf("replay tag %0d addr %h, expected tag %0d addr %h",
                             $sampled(replay_rd), $sampled(replay_paddr),
                             $sampled(exp_rd), $sampled(exp_paddr)));

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: run still going after %0d cycles", MAX_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // Expected result of a load in EX2
  // --------------------------------------------------
  function automatic byte mem_byte(input lsu_cfg_pkg::paddr_t addr);
    return addr[7:0] * 8'h9d + 8'h3b;
  endfunction

  // Lowest source index wins, uncovered bytes come from memory
  function automatic slot_t merge_expected(input slot_t rec);
    int                  nbytes;
    int                  lane;
    logic                got;
    logic                all_fwd;
    logic [7:0]          b;
    lsu_cfg_pkg::data_t  val;
    nbytes  = 1 << rec.size;
    all_fwd = 1'b1;
    val     = '0;
    for (int j = 0; j < nbytes; j++) begin
      lane = rec.addr[2:0] + j;
      got  = 1'b0;
      b    = mem_byte(rec.addr + j);
      for (int src = 0; src < lsu_cfg_pkg::FWD_SRC_NUM; src++) begin
        if (fwd_dw[src][lane]) begin
          b   = fwd_data[src][lane*8 +: 8];
          got = 1'b1;
          break;
        end
      end
      all_fwd        = all_fwd & got;
      val[j*8 +: 8]  = b;
    end
    if (nbytes < 8 && rec.sign == lsu_op_pkg::SIGN_S && val[nbytes*8-1]) begin
      val = val | (~64'h0 << (nbytes * 8));
    end
    rec.data   = val;
    rec.replay = !all_fwd && rec.addr[6];
    return rec;
  endfunction

  // --------------------------------------------------
  // One clock cycle of stimulus and expectation
  // --------------------------------------------------
  task automatic run_cycle(input logic do_issue, input int hit_mode, input logic do_kill);
    slot_t               rec;
    slot_t               ex1;
    slot_t               ex3;
    lsu_cfg_pkg::data_t  sum;
    int                  nbytes;
    @(posedge clk);
    #1;
    rec = '0;
    if (do_issue) begin
      rec.size     = lsu_op_pkg::size_e'($urandom_range(3, 0));
      rec.sign     = lsu_op_pkg::sign_e'($urandom_range(1, 0));
      rec.rd       = lsu_cfg_pkg::rd_tag_t'($urandom);
      nbytes       = 1 << rec.size;
      issue_base   = {$urandom, $urandom} & ~lsu_cfg_pkg::data_t'(nbytes - 1);
      issue_offset = lsu_cfg_pkg::offset_t'($urandom) & ~lsu_cfg_pkg::offset_t'(nbytes - 1);
      sum          = issue_base + {{52{issue_offset[11]}}, issue_offset};
      // Moving the base by 64 bytes flips hit and miss
      if ((hit_mode == HIT && sum[6]) || (hit_mode == MISS && !sum[6])) begin
        issue_base = issue_base ^ 64'h40;
        sum        = issue_base + {{52{issue_offset[11]}}, issue_offset};
      end
      rec.valid = 1'b1;
      rec.addr  = sum[39:0];
    end
    issue_valid = do_issue;
    issue_size  = rec.size;
    issue_sign  = rec.sign;
    issue_rd    = rec.rd;
    kill        = do_kill;
    pipe_q.push_back(rec);
    void'(pipe_q.pop_front());

    @(negedge clk);
    pipe_q[1]        = merge_expected(pipe_q[1]);
    ex1              = pipe_q[2];
    rec              = pipe_q[1];
    ex3              = pipe_q[0];
    exp_rd_valid     = ex1.valid;
    exp_line         = {ex1.addr[39:4], 4'h0};
    exp_chk_valid    = rec.valid;
    exp_chk_paddr    = {rec.addr[39:3], 3'h0};
    exp_chk_dw       = lsu_cfg_pkg::byte_mask_t'(((1 << (1 << rec.size)) - 1) << rec.addr[2:0]);
    exp_wb_valid     = ex3.valid && !ex3.replay;
    exp_replay_valid = ex3.valid && ex3.replay;
    exp_rd           = ex3.rd;
    exp_data         = ex3.data;
    exp_paddr        = ex3.addr;
    // Kill drops EX0 to EX2 after this cycle's checks
    if (do_kill) begin
      for (int i = 1; i < 4; i++) begin
        rec       = pipe_q[i];
        rec.valid = 1'b0;
        pipe_q[i] = rec;
      end
    end
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    void'($urandom(SEED));
    reset_n          = 1'b0;
    kill             = 1'b0;
    issue_valid      = 1'b0;
    issue_base       = '0;
    issue_offset     = '0;
    issue_size       = lsu_op_pkg::SIZE_B;
    issue_sign       = lsu_op_pkg::SIGN_U;
    issue_rd         = '0;
    fwd_on           = 1'b0;
    exp_rd_valid     = 1'b0;
    exp_chk_valid    = 1'b0;
    exp_wb_valid     = 1'b0;
    exp_replay_valid = 1'b0;
    exp_line         = '0;
    exp_chk_paddr    = '0;
    exp_chk_dw       = '0;
    exp_rd           = '0;
    exp_data         = '0;
    exp_paddr        = '0;
    repeat (4) pipe_q.push_back('0);
    repeat (4) @(posedge clk);
    #1 reset_n = 1'b1;

    // Idle pipe, then hits with no forwarding back to back
    repeat (6) run_cycle(1'b0, ANY, 1'b0);
    repeat (24) run_cycle(1'b1, HIT, 1'b0);
    // Partial and overlapping forwarding, full cover on misses
    fwd_on = 1'b1;
    repeat (40) run_cycle(1'b1, HIT, 1'b0);
    repeat (60) run_cycle(1'b1, MISS, 1'b0);
    // Misses with nothing forwarded must replay
    fwd_on = 1'b0;
    repeat (12) run_cycle(1'b1, MISS, 1'b0);
    // Kill with a load in every stage
    fwd_on = 1'b1;
    repeat (3) run_cycle(1'b1, ANY, 1'b0);
    run_cycle(1'b1, ANY, 1'b1);
    repeat (6) run_cycle(1'b1, ANY, 1'b0);
    // Mixed traffic with gaps and occasional kills
    repeat (300) run_cycle($urandom_range(3, 0) != 0, ANY, $urandom_range(15, 0) == 0);
    repeat (4) run_cycle(1'b0, ANY, 1'b0);

    $display("Errors: %0d", err_count);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
